// File: rtl/rv_pkg.sv
// Widths, memory sizes and encodings shared by all pipeline stages, imported by each RTL module
`default_nettype none

package rv_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int num_regs    = 32;
    localparam int imem_words  = 128;
    localparam int imem_addr_w = 7;   // Word index into instruction memory
    localparam int dmem_bytes  = 512;
    localparam int dmem_addr_w = 9;   // Byte address into data memory

    // Major opcodes accepted by the decoder, anything else is a bubble
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // LUI
    } alu_op_e;

    // Second ALU operand, also picks the immediate format in decode
    typedef enum logic [1:0] {
        OPB_REG   = 2'd0,
        OPB_IMM_I = 2'd1,
        OPB_IMM_S = 2'd2,
        OPB_IMM_U = 2'd3
    } opb_sel_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire

// File: rtl/register_file.sv
// General register file with x0 fixed at zero, one write port and two read ports for decode
`timescale 1ns/1ns
`default_nettype none

module register_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    input  logic [reg_addr_w-1:0] raddr_a,
    input  logic [reg_addr_w-1:0] raddr_b,
    output logic [xlen-1:0]       rdata_a,
    output logic [xlen-1:0]       rdata_b
);

    logic [xlen-1:0]     regs [num_regs];
    logic [num_regs-1:1] wen;  // One-hot write select

    assign regs[0] = '0;

    for (genvar i = 1; i < num_regs; i++) begin : g_reg
        logic [xlen-1:0] q;

        assign wen[i] = we && (waddr == reg_addr_w'(i));

        always_ff @(posedge clk) begin
            if (reset) begin
                q <= '0;
            end else if (wen[i]) begin
                q <= wdata;
            end
        end

        assign regs[i] = q;
    end

    // Reads see the value before a same-cycle write
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Fetch stage holding the PC, the loadable instruction memory and the IF/ID register
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [xlen-1:0]        prog_data,
    output logic [xlen-1:0]        id_instr,
    output logic [xlen-1:0]        id_pc
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] if_instr;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign if_instr = imem[pc[imem_addr_w+1:2]];  // Word address of the PC

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + xlen'(4);
        end
    end

    // A zero word goes down the pipe as a bubble while stopped
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            id_instr <= '0;
        end else begin
            id_instr <= if_instr;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Decode stage with control decoding, immediate building, register file reads and the ID/EX register
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       id_instr,
    input  logic [xlen-1:0]       id_pc,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output alu_op_e               ex_alu_op,
    output opb_sel_e              ex_opb_sel,
    output logic                  ex_use_pc,
    output logic                  ex_reg_we,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write,
    output mem_size_e             ex_mem_size,
    output logic                  ex_load_signed,
    output logic [xlen-1:0]       ex_rs1_val,
    output logic [xlen-1:0]       ex_rs2_val,
    output logic [xlen-1:0]       ex_imm,
    output logic [xlen-1:0]       ex_pc,
    output logic [reg_addr_w-1:0] ex_rd
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    opb_sel_e              opb_sel;
    logic                  use_pc;
    logic                  reg_we;
    logic                  mem_read;
    logic                  mem_write;
    mem_size_e             mem_size;
    logic                  load_signed;

    // Bit 30 picks SUB only for register forms, SRA for both
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt,
                                                input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic mem_size_e size_from_funct3(input logic [1:0] f3);
        case (f3)
            2'b00:   return SIZE_BYTE;
            2'b01:   return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    assign opcode = opcode_e'(id_instr[6:0]);
    assign funct3 = id_instr[14:12];
    assign rd     = id_instr[11:7];

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .we      (wb_we),
        .waddr   (wb_rd),
        .wdata   (wb_data),
        .raddr_a (id_instr[19:15]),
        .raddr_b (id_instr[24:20]),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val)
    );

    always_comb begin
        alu_op      = ALU_ADD;
        opb_sel     = OPB_REG;
        use_pc      = 1'b0;
        reg_we      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_size    = SIZE_WORD;
        load_signed = 1'b0;
        case (opcode)
            OP_REG: begin
                alu_op = alu_from_funct3(funct3, id_instr[30], 1'b1);
                reg_we = 1'b1;
            end
            OP_IMM: begin
                alu_op  = alu_from_funct3(funct3, id_instr[30], 1'b0);
                opb_sel = OPB_IMM_I;
                reg_we  = 1'b1;
            end
            OP_LOAD: begin
                opb_sel     = OPB_IMM_I;  // Address is rs1 plus offset
                reg_we      = 1'b1;
                mem_read    = 1'b1;
                mem_size    = size_from_funct3(funct3[1:0]);
                load_signed = !funct3[2];
            end
            OP_STORE: begin
                opb_sel   = OPB_IMM_S;
                mem_write = 1'b1;
                mem_size  = size_from_funct3(funct3[1:0]);
            end
            OP_LUI: begin
                alu_op  = ALU_PASS_B;
                opb_sel = OPB_IMM_U;
                reg_we  = 1'b1;
            end
            OP_AUIPC: begin
                opb_sel = OPB_IMM_U;
                use_pc  = 1'b1;
                reg_we  = 1'b1;
            end
            default: begin
                reg_we = 1'b0;  // Zero word or unknown opcode
            end
        endcase
    end

    // Immediate in the format the operand select asks for
    always_comb begin
        case (opb_sel)
            OPB_IMM_S: imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            OPB_IMM_U: imm = {id_instr[31:12], 12'b0};
            default:   imm = {{20{id_instr[31]}}, id_instr[31:20]};
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_alu_op      <= ALU_ADD;
            ex_opb_sel     <= OPB_REG;
            ex_use_pc      <= 1'b0;
            ex_reg_we      <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_mem_size    <= SIZE_WORD;
            ex_load_signed <= 1'b0;
        end else begin
            ex_alu_op      <= alu_op;
            ex_opb_sel     <= opb_sel;
            ex_use_pc      <= use_pc;
            ex_reg_we      <= reg_we && (rd != '0);  // x0 is never written
            ex_mem_read    <= mem_read;
            ex_mem_write   <= mem_write;
            ex_mem_size    <= mem_size;
            ex_load_signed <= load_signed;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
        ex_imm     <= imm;
        ex_pc      <= id_pc;
        ex_rd      <= rd;
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage with operand selection, the ALU and the EX/MEM register
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  alu_op_e               ex_alu_op,
    input  opb_sel_e              ex_opb_sel,
    input  logic                  ex_use_pc,
    input  logic                  ex_reg_we,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    input  mem_size_e             ex_mem_size,
    input  logic                  ex_load_signed,
    input  logic [xlen-1:0]       ex_rs1_val,
    input  logic [xlen-1:0]       ex_rs2_val,
    input  logic [xlen-1:0]       ex_imm,
    input  logic [xlen-1:0]       ex_pc,
    input  logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       mem_result,
    output logic [xlen-1:0]       mem_store_val,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_reg_we,
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_size_e             mem_size,
    output logic                  mem_load_signed
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;

    assign op_a  = ex_use_pc ? ex_pc : ex_rs1_val;  // PC only for AUIPC
    assign op_b  = (ex_opb_sel == OPB_REG) ? ex_rs2_val : ex_imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = xlen'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = xlen'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);  // Sign fill
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_reg_we      <= 1'b0;
            mem_read        <= 1'b0;
            mem_write       <= 1'b0;
            mem_size        <= SIZE_WORD;
            mem_load_signed <= 1'b0;
        end else begin
            mem_reg_we      <= ex_reg_we;
            mem_read        <= ex_mem_read;
            mem_write       <= ex_mem_write;
            mem_size        <= ex_mem_size;
            mem_load_signed <= ex_load_signed;
        end
    end

    always_ff @(posedge clk) begin
        mem_result    <= alu_out;
        mem_store_val <= ex_rs2_val;
        mem_rd        <= ex_rd;
    end

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
// Memory stage with the byte data memory, store lane placement, load extension and MEM/WB register
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [xlen-1:0]        mem_result,
    input  logic [xlen-1:0]        mem_store_val,
    input  logic [reg_addr_w-1:0]  mem_rd,
    input  logic                   mem_reg_we,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  mem_size_e              mem_size,
    input  logic                   mem_load_signed,
    output logic                   store_valid,
    output logic [dmem_addr_w-1:0] store_addr,
    output logic [xlen-1:0]        store_data,
    output logic [3:0]             store_strobe,
    output logic                   wb_we,
    output logic [reg_addr_w-1:0]  wb_rd,
    output logic [xlen-1:0]        wb_data
);

    logic [7:0]             dmem [dmem_bytes];
    logic [dmem_addr_w-1:0] addr;
    logic [dmem_addr_w-1:0] word_base;
    logic [1:0]             offset;
    logic [3:0]             size_mask;
    logic [xlen-1:0]        word_rd;
    logic [xlen-1:0]        lane_rd;
    logic [xlen-1:0]        load_val;

    assign addr      = mem_result[dmem_addr_w-1:0];
    assign offset    = addr[1:0];
    assign word_base = {addr[dmem_addr_w-1:2], 2'b00};

    always_comb begin
        case (mem_size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    // Store ports, lanes follow the byte offset within the word
    assign store_valid  = mem_write;
    assign store_addr   = addr;
    assign store_strobe = size_mask << offset;
    assign store_data   = mem_store_val << {offset, 3'b000};

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_write && store_strobe[b]) begin
                dmem[word_base + dmem_addr_w'(b)] <= store_data[8*b +: 8];
            end
        end
    end

    assign word_rd = {dmem[word_base + dmem_addr_w'(3)], dmem[word_base + dmem_addr_w'(2)],
                      dmem[word_base + dmem_addr_w'(1)], dmem[word_base]};
    assign lane_rd = word_rd >> {offset, 3'b000};  // Addressed byte down to bit 0

    always_comb begin
        case (mem_size)
            SIZE_BYTE: load_val = {{24{mem_load_signed & lane_rd[7]}}, lane_rd[7:0]};
            SIZE_HALF: load_val = {{16{mem_load_signed & lane_rd[15]}}, lane_rd[15:0]};
            default:   load_val = lane_rd;
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_read ? load_val : mem_result;
    end

endmodule

`default_nettype wire

// File: rtl/rv_pipeline.sv
// Top of the five-stage RV32I subset pipeline with the program-load and store-observation ports
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [imem_addr_w-1:0] prog_addr,
    input  logic [xlen-1:0]        prog_data,
    output logic                   store_valid,
    output logic [dmem_addr_w-1:0] store_addr,
    output logic [xlen-1:0]        store_data,
    output logic [3:0]             store_strobe
);

    // IF/ID
    logic [xlen-1:0]       id_instr;
    logic [xlen-1:0]       id_pc;

    // ID/EX
    alu_op_e               ex_alu_op;
    opb_sel_e              ex_opb_sel;
    logic                  ex_use_pc;
    logic                  ex_reg_we;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    mem_size_e             ex_mem_size;
    logic                  ex_load_signed;
    logic [xlen-1:0]       ex_rs1_val;
    logic [xlen-1:0]       ex_rs2_val;
    logic [xlen-1:0]       ex_imm;
    logic [xlen-1:0]       ex_pc;
    logic [reg_addr_w-1:0] ex_rd;

    // EX/MEM
    logic [xlen-1:0]       mem_result;
    logic [xlen-1:0]       mem_store_val;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_reg_we;
    logic                  mem_read;
    logic                  mem_write;
    mem_size_e             mem_size;
    logic                  mem_load_signed;

    // MEM/WB back to the register file
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    fetch_stage i_fetch_stage (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .id_instr  (id_instr),
        .id_pc     (id_pc)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .id_instr       (id_instr),
        .id_pc          (id_pc),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .ex_alu_op      (ex_alu_op),
        .ex_opb_sel     (ex_opb_sel),
        .ex_use_pc      (ex_use_pc),
        .ex_reg_we      (ex_reg_we),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_mem_size    (ex_mem_size),
        .ex_load_signed (ex_load_signed),
        .ex_rs1_val     (ex_rs1_val),
        .ex_rs2_val     (ex_rs2_val),
        .ex_imm         (ex_imm),
        .ex_pc          (ex_pc),
        .ex_rd          (ex_rd)
    );

    execute_stage i_execute_stage (
        .clk             (clk),
        .reset           (reset),
        .ex_alu_op       (ex_alu_op),
        .ex_opb_sel      (ex_opb_sel),
        .ex_use_pc       (ex_use_pc),
        .ex_reg_we       (ex_reg_we),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .ex_mem_size     (ex_mem_size),
        .ex_load_signed  (ex_load_signed),
        .ex_rs1_val      (ex_rs1_val),
        .ex_rs2_val      (ex_rs2_val),
        .ex_imm          (ex_imm),
        .ex_pc           (ex_pc),
        .ex_rd           (ex_rd),
        .mem_result      (mem_result),
        .mem_store_val   (mem_store_val),
        .mem_rd          (mem_rd),
        .mem_reg_we      (mem_reg_we),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_size        (mem_size),
        .mem_load_signed (mem_load_signed)
    );

    memory_stage i_memory_stage (
        .clk             (clk),
        .reset           (reset),
        .mem_result      (mem_result),
        .mem_store_val   (mem_store_val),
        .mem_rd          (mem_rd),
        .mem_reg_we      (mem_reg_we),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_size        (mem_size),
        .mem_load_signed (mem_load_signed),
        .store_valid     (store_valid),
        .store_addr      (store_addr),
        .store_data      (store_data),
        .store_strobe    (store_strobe),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

`default_nettype wire

// File: test/rv_pipeline_tb.sv
// Testbench for the pipeline that loads the program from the stim file, runs it and checks each store
`timescale 1ns/1ns
`default_nettype none

module rv_pipeline_tb
    import rv_pkg::*;
();

    logic                   clk;
    logic                   reset;
    logic                   run;
    logic                   prog_we;
    logic [imem_addr_w-1:0] prog_addr;
    logic [xlen-1:0]        prog_data;
    logic                   store_valid;
    logic [dmem_addr_w-1:0] store_addr;
    logic [xlen-1:0]        store_data;
    logic [3:0]             store_strobe;

    // Contents of the stim file
    logic [xlen-1:0]        prog_words [$];
    logic [dmem_addr_w-1:0] exp_addr [$];
    logic [3:0]             exp_strobe [$];
    logic [xlen-1:0]        exp_data [$];

    rv_pipeline i_rv_pipeline (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .store_strobe (store_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Lines are P <word>, S <addr> <strobe> <data> or E, and # starts a comment
    task automatic read_stim();
        int               fd;
        int               code;
        int               guard;
        logic [7:0]       kind;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [8*160-1:0] rest;
        bit               seen_end;
        fd = $fopen("test/rv_pipeline_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/rv_pipeline_stim.txt");
            abort_run();
        end
        seen_end = 1'b0;
        guard    = 0;
        while (!seen_end && !$feof(fd) && guard < 2000) begin
            guard++;
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                guard = 2000;  // End of file without a marker
            end else if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h", f1);
                prog_words.push_back(f1);
            end else if (kind == "S") begin
                code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                exp_addr.push_back(f1[dmem_addr_w-1:0]);
                exp_strobe.push_back(f2[3:0]);
                exp_data.push_back(f3);
            end else if (kind == "E") begin
                seen_end = 1'b1;
            end
        end
        $fclose(fd);
        if (!seen_end || prog_words.size() == 0 || prog_words.size() > imem_words) begin
            $display("Stimulus file is malformed or has no end marker");
            abort_run();
        end
    endtask

    task automatic no_store_check(input int cycles, input string phase);
        repeat (cycles) begin
            @(negedge clk);
            check_value({"store_valid ", phase}, 32'(store_valid), 32'd0);
        end
    endtask

    task automatic wait_for_store(input int idx);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (store_valid !== 1'b1 && waited < 200);
        if (store_valid !== 1'b1) begin
            $display("Store %0d to address %h never appeared within 200 cycles",
                     idx, exp_addr[idx]);
            abort_run();
        end
    endtask

    initial begin
        int n;
        reset     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_stim();

        // Program load overlaps the five reset cycles
        n = (prog_words.size() > 5) ? prog_words.size() : 5;
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
            reset <= (c < 4);
            if (c < prog_words.size()) begin
                prog_we   <= 1'b1;
                prog_addr <= imem_addr_w'(c);
                prog_data <= prog_words[c];
            end else begin
                prog_we <= 1'b0;
            end
        end
        @(posedge clk);
        prog_we <= 1'b0;
        no_store_check(8, "while stopped");

        @(posedge clk);
        run <= 1'b1;
        for (int i = 0; i < exp_data.size(); i++) begin
            wait_for_store(i);
            check_value($sformatf("store %0d address", i), 32'(store_addr), 32'(exp_addr[i]));
            check_value($sformatf("store %0d strobe", i), 32'(store_strobe), 32'(exp_strobe[i]));
            check_value($sformatf("store %0d data", i), store_data, exp_data[i]);
        end
        no_store_check(40, "after the last store");

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_pipeline.f
rtl/rv_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv_pipeline.sv
test/rv_pipeline_tb.sv

// File: test/rv_pipeline_stim.txt
# P <instruction word>, S <byte address> <strobe> <store data>, E ends; all hex
# x1 = -100, x2 = 7, readers sit at least four words after their writer
P F9C00093 # addi x1, x0, -100
P 00700113 # addi x2, x0, 7
P 123451B7 # lui x3, 0x12345
P 00001217 # auipc x4, 0x1 at pc 0xc
P 4020D293 # srai x5, x1, 2
P 00208333 # add x6, x1, x2
P 401103B3 # sub x7, x2, x1
P 0020F433 # and x8, x1, x2
P 0020E4B3 # or x9, x1, x2
P 0020C533 # xor x10, x1, x2
P 002115B3 # sll x11, x2, x2
P 0020D633 # srl x12, x1, x2
P 4020D6B3 # sra x13, x1, x2
P 0020A733 # slt x14, x1, x2
P 0020B7B3 # sltu x15, x1, x2
P 00411813 # slli x16, x2, 4
P 0020D893 # srli x17, x1, 2
P FCE0A913 # slti x18, x1, -50
P FFF13993 # sltiu x19, x2, -1
P 0F00FA13 # andi x20, x1, 0xf0
P 70016A93 # ori x21, x2, 0x700
P FFF0CB13 # xori x22, x1, -1
P 00500013 # addi x0, x0, 5
P 10302023 # sw x3, 0x100(x0)
P 10402223 # sw x4, 0x104(x0)
P 10502423 # sw x5, 0x108(x0)
P 10602623 # sw x6, 0x10c(x0)
P 10702823 # sw x7, 0x110(x0)
P 10802A23 # sw x8, 0x114(x0)
P 10902C23 # sw x9, 0x118(x0)
P 10A02E23 # sw x10, 0x11c(x0)
P 12B02023 # sw x11, 0x120(x0)
P 12C02223 # sw x12, 0x124(x0)
P 12D02423 # sw x13, 0x128(x0)
P 12E02623 # sw x14, 0x12c(x0)
P 12F02823 # sw x15, 0x130(x0)
P 13002A23 # sw x16, 0x134(x0)
P 13102C23 # sw x17, 0x138(x0)
P 13202E23 # sw x18, 0x13c(x0)
P 15302023 # sw x19, 0x140(x0)
P 15402223 # sw x20, 0x144(x0)
P 15502423 # sw x21, 0x148(x0)
P 15602623 # sw x22, 0x14c(x0)
P 14002823 # sw x0, 0x150(x0)
P 181000A3 # sb x1, 0x181(x0)
P 18101323 # sh x1, 0x186(x0)
P 18100B83 # lb x23, 0x181(x0)
P 18104C03 # lbu x24, 0x181(x0)
P 18601C83 # lh x25, 0x186(x0)
P 18605D03 # lhu x26, 0x186(x0)
P 19702823 # sw x23, 0x190(x0)
P 19802A23 # sw x24, 0x194(x0)
P 19902C23 # sw x25, 0x198(x0)
P 19A02E23 # sw x26, 0x19c(x0)
S 100 F 12345000
S 104 F 0000100C
S 108 F FFFFFFE7
S 10C F FFFFFFA3
S 110 F 0000006B
S 114 F 00000004
S 118 F FFFFFF9F
S 11C F FFFFFF9B
S 120 F 00000380
S 124 F 01FFFFFF
S 128 F FFFFFFFF
S 12C F 00000001
S 130 F 00000000
S 134 F 00000070
S 138 F 3FFFFFE7
S 13C F 00000001
S 140 F 00000001
S 144 F 00000090
S 148 F 00000707
S 14C F 00000063
S 150 F 00000000
S 181 2 FFFF9C00
S 186 C FF9C0000
S 190 F FFFFFF9C
S 194 F 0000009C
S 198 F FFFFFF9C
S 19C F 0000FF9C
E
